// ==== hdl/ldpc_check_ram.sv ====
module ldpc_check_ram (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       clr,
	input  logic       rd_en,
	input  logic       wr_en,
	input  logic [2:0] rd_addr,
	input  logic [2:0] wr_addr,
	input  logic [7:0] wr_data,
	output logic [7:0] q
);

	logic [7:0] mem [8];
	logic [7:0] entry_vld;

	// per entry valid bits so one cycle of clr empties the whole ram
	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			entry_vld <= '0;
		else if (clr)
			entry_vld <= '0;
		else if (wr_en)
			entry_vld[wr_addr] <= 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// untouched groups read back as zero
	always_ff @(posedge sys_clk) begin
		if (rd_en)
			q <= entry_vld[rd_addr] ? mem[rd_addr] : 8'h00;
	end

	assert property (@(posedge sys_clk) disable iff (!rst_n) !(rd_en && wr_en));

endmodule

// ==== hdl/ldpc_enc_pkg.sv ====
package ldpc_enc_pkg;

	//////////////////////////////////////////////////////////////////////
	// code modes and controller states
	//////////////////////////////////////////////////////////////////////

	// rate picks how many check groups are in use
	typedef enum logic {
		RATE_1_2,
		RATE_2_3
	} ldpc_rate_e;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE,
		DRAIN,
		CLEAR
	} ctrl_state_e;

	//////////////////////////////////////////////////////////////////////
	// beats and operations
	//////////////////////////////////////////////////////////////////////

	// one information byte is one group of Z = 8 bits
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} info_beat_t;

	// one parity byte per check group
	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} parity_beat_t;

	// one read-modify-write on the check ram
	typedef struct packed {
		logic [2:0] addr;
		logic [2:0] shift;
		logic       first;
	} check_op_t;

	// number of check groups P
	function automatic logic [3:0] group_count(input ldpc_rate_e rate);
		return (rate == RATE_1_2) ? 4'd8 : 4'd4;
	endfunction

	// group of byte i slot j is (3i + 5j) mod P
	function automatic logic [2:0] check_addr(input int unsigned i, input int unsigned j,
			input ldpc_rate_e rate);
		int unsigned sum;
		sum = 3 * i + 5 * j;
		// P is a power of two so the modulo is a bit select
		if (rate == RATE_2_3)
			return {1'b0, sum[1:0]};
		return sum[2:0];
	endfunction

	// left rotation of byte i slot j is (i + 2j) mod 8
	function automatic logic [2:0] check_shift(input int unsigned i, input int unsigned j);
		int unsigned sum;
		sum = i + 2 * j;
		return sum[2:0];
	endfunction

endpackage

// ==== hdl/ldpc_encoder_ctrl.sv ====
module ldpc_encoder_ctrl import ldpc_enc_pkg::*; #(
	parameter int WEIGHT         = 3,
	parameter int MAX_INFO_BYTES = 16
) (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  info_beat_t in_beat,
	input  logic       in_valid,
	output logic       in_ready,
	input  ldpc_rate_e rate,
	output logic       byte_load,
	output logic [7:0] byte_data,
	output check_op_t  op,
	output logic       rd_en,
	output logic       wr_en,
	output logic       clr,
	output logic [2:0] rd_addr,
	output logic [2:0] wr_addr,
	input  logic       hold_free,
	output logic       drain_rd,
	output logic       drain_last
);

	localparam int IDX_W  = (MAX_INFO_BYTES > 1) ? $clog2(MAX_INFO_BYTES) : 1;
	localparam int SLOT_W = (WEIGHT > 1) ? $clog2(WEIGHT) : 1;

	ctrl_state_e       state;
	logic [IDX_W-1:0]  byte_idx;
	logic [SLOT_W-1:0] slot;
	logic              last_q;
	ldpc_rate_e        rate_q;
	logic [2:0]        grp;
	logic              drain_done;
	logic [3:0]        p_groups;

	assign p_groups = group_count(rate_q);

	// input side only open while idle
	assign in_ready  = (state == IDLE);
	assign byte_load = in_valid && in_ready;
	assign byte_data = in_beat.data;

	// address and rotation of the current slot
	always_comb begin
		op.addr  = check_addr(byte_idx, slot, rate_q);
		op.shift = check_shift(byte_idx, slot);
		op.first = (slot == '0);
	end

	// drain reads wait for room in the output register
	assign drain_rd   = (state == DRAIN) && !drain_done && hold_free;
	assign drain_last = drain_rd && ({1'b0, grp} == p_groups - 4'd1);

	assign rd_en   = (state == READ) || drain_rd;
	assign rd_addr = (state == DRAIN) ? grp : op.addr;
	assign wr_en   = (state == WRITE);
	assign wr_addr = op.addr;
	assign clr     = (state == CLEAR);

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			byte_idx   <= '0;
			slot       <= '0;
			last_q     <= 1'b0;
			rate_q     <= RATE_1_2;
			grp        <= '0;
			drain_done <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (byte_load) begin
						// rate is sampled with the first byte of a frame
						if (byte_idx == '0)
							rate_q <= rate;
						last_q <= in_beat.last;
						slot   <= '0;
						state  <= READ;
					end
				end
				READ: begin
					state <= WRITE;
				end
				WRITE: begin
					if (slot == SLOT_W'(WEIGHT - 1)) begin
						slot <= '0;
						if (last_q) begin
							byte_idx   <= '0;
							grp        <= '0;
							drain_done <= 1'b0;
							state      <= DRAIN;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state    <= IDLE;
						end
					end else begin
						slot  <= slot + 1'b1;
						state <= READ;
					end
				end
				DRAIN: begin
					if (drain_done) begin
						// free again means the final group has left
						if (hold_free)
							state <= CLEAR;
					end else if (drain_rd) begin
						if (drain_last)
							drain_done <= 1'b1;
						else
							grp <= grp + 1'b1;
					end
				end
				CLEAR: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ram accesses stay inside the groups of the latched rate
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		rd_en |-> ({1'b0, rd_addr} < p_groups));
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		wr_en |-> ({1'b0, wr_addr} < p_groups));

	// an accepted byte blocks the input for all of its slots
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		byte_load |=> !in_ready [*(2 * WEIGHT)]);

endmodule

// ==== hdl/ldpc_encoder_top.sv ====
module ldpc_encoder_top import ldpc_enc_pkg::*; #(
	parameter int WEIGHT         = 3,
	parameter int MAX_INFO_BYTES = 16
) (
	input  logic         sys_clk,
	input  logic         rst_n,
	input  info_beat_t   in_beat,
	input  logic         in_valid,
	output logic         in_ready,
	input  ldpc_rate_e   rate,
	output parity_beat_t out_beat,
	output logic         out_valid,
	input  logic         out_ready
);

	check_op_t  op;
	logic       byte_load;
	logic [7:0] byte_data;
	logic       rd_en;
	logic       wr_en;
	logic       clr;
	logic [2:0] rd_addr;
	logic [2:0] wr_addr;
	logic       hold_free;
	logic       drain_rd;
	logic       drain_last;
	logic [7:0] wr_data;
	logic [7:0] q;

	//////////////////////////////////////////////////////////////////////
	// address and shift generation
	//////////////////////////////////////////////////////////////////////

	ldpc_encoder_ctrl #(
		.WEIGHT         (WEIGHT),
		.MAX_INFO_BYTES (MAX_INFO_BYTES)
	) uut_ldpc_encoder_ctrl (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.in_beat    (in_beat),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.rate       (rate),
		.byte_load  (byte_load),
		.byte_data  (byte_data),
		.op         (op),
		.rd_en      (rd_en),
		.wr_en      (wr_en),
		.clr        (clr),
		.rd_addr    (rd_addr),
		.wr_addr    (wr_addr),
		.hold_free  (hold_free),
		.drain_rd   (drain_rd),
		.drain_last (drain_last)
	);

	// q feeds the update path and the output stage
	ldpc_check_ram uut_ldpc_check_ram (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.clr     (clr),
		.rd_en   (rd_en),
		.wr_en   (wr_en),
		.rd_addr (rd_addr),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.q       (q)
	);

	ldpc_parity_update uut_ldpc_parity_update (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.byte_load (byte_load),
		.byte_data (byte_data),
		.op        (op),
		.wr_en     (wr_en),
		.q         (q),
		.wr_data   (wr_data)
	);

	// only drain reads load the output stage
	ldpc_parity_out uut_ldpc_parity_out (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.load       (drain_rd),
		.drain_last (drain_last),
		.q          (q),
		.hold_free  (hold_free),
		.out_beat   (out_beat),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

endmodule

// ==== hdl/ldpc_parity_out.sv ====
module ldpc_parity_out import ldpc_enc_pkg::*; (
	input  logic         sys_clk,
	input  logic         rst_n,
	input  logic         load,
	input  logic         drain_last,
	input  logic [7:0]   q,
	output logic         hold_free,
	output parity_beat_t out_beat,
	output logic         out_valid,
	input  logic         out_ready
);

	logic       load_q;
	logic       last_q;
	logic       frame_start;
	logic       acc;
	logic       run_bit;
	logic [7:0] chain;

	//////////////////////////////////////////////////////////////////////
	// accumulator chain
	//////////////////////////////////////////////////////////////////////

	// bit 0 first and each output bit is the running xor
	always_comb begin
		run_bit = frame_start ? 1'b0 : acc;
		for (int b = 0; b < 8; b++) begin
			run_bit  = run_bit ^ q[b];
			chain[b] = run_bit;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			load_q      <= 1'b0;
			last_q      <= 1'b0;
			frame_start <= 1'b1;
			acc         <= 1'b0;
			out_valid   <= 1'b0;
		end else begin
			// q arrives one cycle after the read
			load_q <= load;
			last_q <= drain_last;
			if (load_q) begin
				acc         <= chain[7];
				frame_start <= last_q;
				out_valid   <= 1'b1;
			end else if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	// holding register
	always_ff @(posedge sys_clk) begin
		if (load_q) begin
			out_beat.data <= chain;
			out_beat.last <= last_q;
		end
	end

	// empty now or emptied this cycle and no load pending
	assign hold_free = !load_q && (!out_valid || out_ready);

	// controller only reads when the register will be free
	assert property (@(posedge sys_clk) disable iff (!rst_n) load_q |-> !out_valid);

	// stalled beat stays put
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

// ==== hdl/ldpc_parity_update.sv ====
module ldpc_parity_update import ldpc_enc_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       byte_load,
	input  logic [7:0] byte_data,
	input  check_op_t  op,
	input  logic       wr_en,
	input  logic [7:0] q,
	output logic [7:0] wr_data
);

	logic [7:0]  info_q;
	logic [15:0] doubled;
	logic [7:0]  rotated;

	//////////////////////////////////////////////////////////////////////
	// held information byte
	//////////////////////////////////////////////////////////////////////

	// kept for all slots of the byte
	always_ff @(posedge sys_clk) begin
		if (byte_load)
			info_q <= byte_data;
	end

	//////////////////////////////////////////////////////////////////////
	// cyclic shift and xor
	//////////////////////////////////////////////////////////////////////

	// rotate left by op.shift
	// upper half of the shifted pair holds the wrapped bits
	assign doubled = {info_q, info_q} << op.shift;
	assign rotated = doubled[15:8];

	// q is the check word read one cycle earlier
	assign wr_data = q ^ rotated;

	// a new byte never lands on a write-back cycle
	assert property (@(posedge sys_clk) disable iff (!rst_n) !(byte_load && wr_en));

	// first slot write sees the byte loaded two cycles before
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		(wr_en && op.first) |-> $past(byte_load, 2));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module ldpc_encoder_tb -o ldpc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ldpc_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== sim.f ====
hdl/ldpc_enc_pkg.sv
hdl/ldpc_encoder_ctrl.sv
hdl/ldpc_check_ram.sv
hdl/ldpc_parity_update.sv
hdl/ldpc_parity_out.sv
hdl/ldpc_encoder_top.sv
test/tb_clock_gen.sv
test/ldpc_encoder_tb.sv

// ==== test/ldpc_encoder_tb.sv ====
module ldpc_encoder_tb import ldpc_enc_pkg::*; ();

	localparam int WEIGHT         = 3;
	localparam int MAX_INFO_BYTES = 16;
	localparam int NUM_FRAMES     = 24;
	localparam int SEED           = 71604;

	logic         sys_clk;
	logic         rst_n;
	info_beat_t   in_beat;
	logic         in_valid;
	logic         in_ready;
	ldpc_rate_e   rate;
	parity_beat_t out_beat;
	logic         out_valid;
	logic         out_ready;

	logic [15:0]  lfsr;
	int           mismatch_cnt;
	int           other_cnt;
	int           cycle_cnt;
	int           cycle_limit;
	int           frame_len [NUM_FRAMES];
	ldpc_rate_e   frame_rate [NUM_FRAMES];
	logic [7:0]   frame_bytes [MAX_INFO_BYTES];
	parity_beat_t expected [$];

	tb_clock_gen #(
		.PERIOD       (20),
		.RESET_CYCLES (3)
	) clk_gen0 (
		.sys_clk (sys_clk),
		.rst_n   (rst_n)
	);

	ldpc_encoder_top #(
		.WEIGHT         (WEIGHT),
		.MAX_INFO_BYTES (MAX_INFO_BYTES)
	) dut0 (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.rate      (rate),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	//////////////////////////////////////////////////////////////////////
	// random source
	//////////////////////////////////////////////////////////////////////

	// fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_next_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	// one lfsr step per bit, msb first
	function automatic int unsigned rand_bits(input int n);
		int unsigned r;
		r = 0;
		for (int k = 0; k < n; k++)
			r = (r << 1) | 32'(lfsr_next_bit());
		return r;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// check groups from the connection rule, then the accumulator chain
	task automatic build_expected(input ldpc_rate_e r, input int len);
		int           p;
		int           g;
		int           s;
		logic [7:0]   checks [8];
		logic [7:0]   b;
		logic [7:0]   rot;
		logic         acc;
		parity_beat_t beat;
		p = (r == RATE_1_2) ? 8 : 4;
		for (int k = 0; k < 8; k++)
			checks[k] = 8'h00;
		for (int i = 0; i < len; i++) begin
			b = frame_bytes[i];
			for (int j = 0; j < WEIGHT; j++) begin
				// group (3i + 5j) mod P, left rotation (i + 2j) mod 8
				g   = (3 * i + 5 * j) % p;
				s   = (i + 2 * j) % 8;
				rot = (b << s) | (b >> (8 - s));
				checks[g] = checks[g] ^ rot;
			end
		end
		// accumulator restarts at zero for every frame
		acc = 1'b0;
		for (int k = 0; k < p; k++) begin
			for (int n = 0; n < 8; n++) begin
				acc          = acc ^ checks[k][n];
				beat.data[n] = acc;
			end
			beat.last = (k == p - 1);
			expected.push_back(beat);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_parity(input string name, input parity_beat_t exp,
			input parity_beat_t act);
		if (act !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s: expected data=%02h last=%0b, actual data=%02h last=%0b",
				name, exp.data, exp.last, act.data, act.last);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			mismatch_cnt++;
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one frame in, its parity bytes out
	//////////////////////////////////////////////////////////////////////

	task automatic run_frame(input int f);
		int           len;
		int           p;
		int           accepted;
		int           received;
		logic         taken;
		logic         stall_en;
		logic         done;
		parity_beat_t exp_beat;
		len = frame_len[f];
		p   = (frame_rate[f] == RATE_1_2) ? 8 : 4;
		for (int i = 0; i < len; i++)
			frame_bytes[i] = 8'(rand_bits(8));
		build_expected(frame_rate[f], len);
		stall_en = lfsr_next_bit();
		accepted = 0;
		received = 0;
		taken    = 1'b0;
		done     = 1'b0;
		while (!done) begin
			@(negedge sys_clk);
			// previous frame has fully left by this edge
			// rate then stays put until the last parity byte of this frame
			rate = frame_rate[f];
			// byte accepted on the last edge, drop valid and maybe offer the next
			if (taken) begin
				in_valid = 1'b0;
				taken    = 1'b0;
			end
			if (!in_valid && accepted < len && rand_bits(2) != 0) begin
				in_beat.data = frame_bytes[accepted];
				in_beat.last = (accepted == len - 1);
				in_valid     = 1'b1;
			end
			// in_ready follows the controller state only
			// so the handshake of the coming edge is already known
			if (in_valid && in_ready) begin
				taken = 1'b1;
				accepted++;
			end
			out_ready = stall_en ? (rand_bits(2) != 0) : 1'b1;
			// out_valid and out_beat are registers and stable here
			if (out_valid && out_ready) begin
				received++;
				if (expected.size() == 0) begin
					other_cnt++;
					$display("frame %0d: parity byte %0d came beyond the frame length",
						f, received);
				end else begin
					exp_beat = expected.pop_front();
					check_parity($sformatf("frame %0d parity byte %0d", f, received - 1),
						exp_beat, out_beat);
				end
				done = out_beat.last;
			end
		end
		check_count($sformatf("frame %0d accepted bytes", f), len, accepted);
		check_count($sformatf("frame %0d parity bytes", f), p, received);
		expected.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin : watchdog
		cycle_cnt = 0;
		@(posedge sys_clk);
		while (cycle_cnt < cycle_limit) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		other_cnt++;
		$display("timeout: the frames did not complete within %0d cycles", cycle_limit);
		$display("errors: mismatch %0d, other %0d", mismatch_cnt, other_cnt);
		$display("TESTBENCH FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int total;
		lfsr         = SEED[15:0];
		mismatch_cnt = 0;
		other_cnt    = 0;
		in_beat      = '0;
		in_valid     = 1'b0;
		rate         = RATE_1_2;
		out_ready    = 1'b0;
		// frame list
		// two single bytes, one full frame, alternating rates, then random rates
		total = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (f < 2)
				frame_len[f] = 1;
			else if (f == 2)
				frame_len[f] = MAX_INFO_BYTES;
			else
				frame_len[f] = int'(rand_bits(4)) + 1;
			if (f < 14)
				frame_rate[f] = (f % 2 == 0) ? RATE_1_2 : RATE_2_3;
			else
				frame_rate[f] = lfsr_next_bit() ? RATE_2_3 : RATE_1_2;
			total += frame_len[f];
		end
		cycle_limit = 40 * (total * (2 * WEIGHT + 2)) + 2000;
		wait (rst_n === 1'b1);
		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f);
		// nothing more may come out once all frames are done
		out_ready = 1'b1;
		repeat (16) begin
			@(negedge sys_clk);
			if (out_valid) begin
				other_cnt++;
				$display("a parity byte appeared after the last frame had ended");
			end
		end
		if (!in_ready) begin
			other_cnt++;
			$display("the input did not return to ready after the last frame");
		end
		$display("errors: mismatch %0d, other %0d", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic sys_clk,
	output logic rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #(PERIOD / 2) sys_clk = ~sys_clk;
	end

	// synchronous reset held low over the first rising edges
	// released on a falling edge like every other input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;
	end

endmodule
